// ==== source/ctrl_pkg.sv ====
package ctrl_pkg;

  localparam int DATA_W = 8;
  localparam int FLAG_W = 9;

  // Instruction bytes and status masks
  typedef logic [DATA_W-1:0] data_t;
  // Status bits 7..0 plus the page-carry bit of the PC adder
  typedef logic [FLAG_W-1:0] flag_t;

  typedef logic [2:0] reg_sel_t;
  typedef logic [3:0] alu_ctrl_t;
  typedef logic [2:0] alu_src_a_t;
  typedef logic [1:0] alu_src_b_t;
  typedef logic [2:0] psrc_t;
  typedef logic [1:0] pcadder_t;
  typedef logic [1:0] pcl_src_t;
  typedef logic [0:0] pch_src_t;
  typedef logic [2:0] abl_src_t;
  typedef logic [2:0] abh_src_t;
  typedef logic [2:0] db_src_t;

  typedef enum logic [5:0] {
    OP_NOP, OP_LDA, OP_LDX, OP_LDY, OP_STA, OP_STX, OP_STY,
    OP_TAX, OP_TAY, OP_TSX, OP_TXA, OP_TXS, OP_TYA,
    OP_ADC, OP_AND, OP_CMP, OP_CPX, OP_CPY, OP_EOR, OP_ORA, OP_SBC,
    OP_INX, OP_INY, OP_DEX, OP_DEY,
    OP_ASL, OP_LSR, OP_ROL, OP_ROR,
    OP_CLC, OP_CLD, OP_CLI, OP_CLV, OP_SEC, OP_SED, OP_SEI,
    OP_JMP,
    OP_BCC, OP_BCS, OP_BEQ, OP_BNE, OP_BMI, OP_BPL, OP_BVC, OP_BVS
  } op_t;

  typedef enum logic [2:0] {IMP, ACC, IMM, ZPG, ABS, REL} addr_mode_t;

  typedef enum logic [2:0] {
    T0_FETCH_OPCODE,
    T1_FETCH_OPERAND,
    T2_ABS,
    T2_REL,
    T3_REL,
    TX_READ_DATA,
    TX_WRITE_DATA
  } cycle_state_t;

  // Register source and destination codes
  localparam reg_sel_t REG_A   = 3'd0;
  localparam reg_sel_t REG_X   = 3'd1;
  localparam reg_sel_t REG_Y   = 3'd2;
  localparam reg_sel_t REG_S   = 3'd3;
  localparam reg_sel_t REG_T   = 3'd4;
  localparam reg_sel_t REG_P   = 3'd5;
  localparam reg_sel_t REG_MEM = 3'd6;
  localparam reg_sel_t REG_ALU = 3'd7;

  localparam alu_ctrl_t ALU_THA = 4'd0;
  localparam alu_ctrl_t ALU_ADC = 4'd1;
  localparam alu_ctrl_t ALU_AND = 4'd2;
  localparam alu_ctrl_t ALU_CMP = 4'd3;
  localparam alu_ctrl_t ALU_DEC = 4'd4;
  localparam alu_ctrl_t ALU_EOR = 4'd5;
  localparam alu_ctrl_t ALU_INC = 4'd6;
  localparam alu_ctrl_t ALU_ORA = 4'd7;
  localparam alu_ctrl_t ALU_SBC = 4'd8;
  localparam alu_ctrl_t ALU_ASL = 4'd9;
  localparam alu_ctrl_t ALU_LSR = 4'd10;
  localparam alu_ctrl_t ALU_ROL = 4'd11;
  localparam alu_ctrl_t ALU_ROR = 4'd12;

  localparam alu_src_a_t ALU_SRC_A_A   = 3'd0;
  localparam alu_src_a_t ALU_SRC_A_X   = 3'd1;
  localparam alu_src_a_t ALU_SRC_A_Y   = 3'd2;
  localparam alu_src_a_t ALU_SRC_A_T   = 3'd3;
  localparam alu_src_a_t ALU_SRC_A_MEM = 3'd4;

  localparam alu_src_b_t ALU_SRC_B_T   = 2'd0;
  localparam alu_src_b_t ALU_SRC_B_MEM = 2'd1;

  localparam psrc_t P_SRC_ALU = 3'd0;
  localparam psrc_t P_SRC_SET = 3'd1;
  localparam psrc_t P_SRC_CLR = 3'd2;
  localparam psrc_t P_SRC_NON = 3'd3;

  localparam pcadder_t PCADDER_NOP  = 2'd0;
  localparam pcadder_t PCADDER_INC  = 2'd1;
  localparam pcadder_t PCADDER_ADD  = 2'd2;
  localparam pcadder_t PCADDER_CADD = 2'd3;

  localparam pcl_src_t PCL_SRC_MEM = 2'd0;
  localparam pcl_src_t PCL_SRC_T   = 2'd1;
  localparam pcl_src_t PCL_SRC_ADD = 2'd2;
  localparam pch_src_t PCH_SRC_MEM = 1'b0;
  localparam pch_src_t PCH_SRC_ADD = 1'b1;

  // PCN is the adder output, PCC the current PC
  localparam abl_src_t ABL_SRC_PCN = 3'd0;
  localparam abl_src_t ABL_SRC_PCC = 3'd1;
  localparam abl_src_t ABL_SRC_MEM = 3'd2;
  localparam abl_src_t ABL_SRC_T   = 3'd3;
  localparam abh_src_t ABH_SRC_PCN = 3'd0;
  localparam abh_src_t ABH_SRC_PCC = 3'd1;
  localparam abh_src_t ABH_SRC_MEM = 3'd2;
  localparam abh_src_t ABH_SRC_H00 = 3'd5;

  localparam db_src_t DB_A = 3'd0;
  localparam db_src_t DB_X = 3'd1;
  localparam db_src_t DB_Y = 3'd2;
  localparam db_src_t DB_T = 3'd3;

  localparam data_t FLAG_MASK_C   = 8'h01;
  localparam data_t FLAG_MASK_Z   = 8'h02;
  localparam data_t FLAG_MASK_I   = 8'h04;
  localparam data_t FLAG_MASK_D   = 8'h08;
  localparam data_t FLAG_MASK_V   = 8'h40;
  localparam data_t FLAG_MASK_N   = 8'h80;
  localparam flag_t FLAG_MASK_PCC = 9'h100;

  localparam logic RW_READ  = 1'b1;
  localparam logic RW_WRITE = 1'b0;

endpackage

// ==== source/decode_if.sv ====
`timescale 1ns/1ns

interface decode_if;
  import ctrl_pkg::*;

  op_t        op;
  addr_mode_t addr_mode;
  logic       is_load;
  logic       is_store;
  logic       is_transfer;
  logic       is_set;
  logic       is_clear;
  logic       branch_taken;
  reg_sel_t   mov_src;
  reg_sel_t   mov_dst;
  alu_ctrl_t  exe_ctrl;
  alu_src_a_t exe_src_a;
  data_t      flag_mask;

  modport producer (output op, addr_mode, is_load, is_store, is_transfer, is_set,
                    is_clear, branch_taken, mov_src, mov_dst, exe_ctrl, exe_src_a,
                    flag_mask);

  modport sequencer (input op, addr_mode, is_store, branch_taken);

  modport control (input op, addr_mode, is_load, is_store, is_transfer, is_set,
                   is_clear, mov_src, mov_dst, exe_ctrl, exe_src_a, flag_mask);

endinterface

// ==== source/opcode_decoder.sv ====
`timescale 1ns/1ns

module opcode_decoder (
  input  ctrl_pkg::data_t      instr,
  output ctrl_pkg::op_t        op,
  output ctrl_pkg::addr_mode_t addr_mode
);
  import ctrl_pkg::*;

  // Operation, standard 6502 encodings
  always_comb begin
    case (instr)
      8'hA9, 8'hA5, 8'hAD: op = OP_LDA;
      8'hA2, 8'hA6, 8'hAE: op = OP_LDX;
      8'hA0, 8'hA4, 8'hAC: op = OP_LDY;
      8'h85, 8'h8D:        op = OP_STA;
      8'h86, 8'h8E:        op = OP_STX;
      8'h84, 8'h8C:        op = OP_STY;
      8'hAA:               op = OP_TAX;
      8'hA8:               op = OP_TAY;
      8'hBA:               op = OP_TSX;
      8'h8A:               op = OP_TXA;
      8'h9A:               op = OP_TXS;
      8'h98:               op = OP_TYA;
      8'h69, 8'h65, 8'h6D: op = OP_ADC;
      8'h29, 8'h25, 8'h2D: op = OP_AND;
      8'hC9, 8'hC5, 8'hCD: op = OP_CMP;
      8'hE0, 8'hE4, 8'hEC: op = OP_CPX;
      8'hC0, 8'hC4, 8'hCC: op = OP_CPY;
      8'h49, 8'h45, 8'h4D: op = OP_EOR;
      8'h09, 8'h05, 8'h0D: op = OP_ORA;
      8'hE9, 8'hE5, 8'hED: op = OP_SBC;
      8'hE8:               op = OP_INX;
      8'hC8:               op = OP_INY;
      8'hCA:               op = OP_DEX;
      8'h88:               op = OP_DEY;
      8'h0A:               op = OP_ASL;
      8'h4A:               op = OP_LSR;
      8'h2A:               op = OP_ROL;
      8'h6A:               op = OP_ROR;
      8'h18:               op = OP_CLC;
      8'hD8:               op = OP_CLD;
      8'h58:               op = OP_CLI;
      8'hB8:               op = OP_CLV;
      8'h38:               op = OP_SEC;
      8'hF8:               op = OP_SED;
      8'h78:               op = OP_SEI;
      8'h4C:               op = OP_JMP;
      8'h90:               op = OP_BCC;
      8'hB0:               op = OP_BCS;
      8'hF0:               op = OP_BEQ;
      8'hD0:               op = OP_BNE;
      8'h30:               op = OP_BMI;
      8'h10:               op = OP_BPL;
      8'h50:               op = OP_BVC;
      8'h70:               op = OP_BVS;
      // 0xEA and every unsupported byte
      default:             op = OP_NOP;
    endcase
  end

  // Addressing mode
  always_comb begin
    case (instr)
      8'hA9, 8'hA2, 8'hA0, 8'h69, 8'h29, 8'hC9, 8'hE0, 8'hC0, 8'h49, 8'h09,
      8'hE9:
        addr_mode = IMM;
      8'hA5, 8'hA6, 8'hA4, 8'h85, 8'h86, 8'h84, 8'h65, 8'h25, 8'hC5, 8'hE4,
      8'hC4, 8'h45, 8'h05, 8'hE5:
        addr_mode = ZPG;
      8'hAD, 8'hAE, 8'hAC, 8'h8D, 8'h8E, 8'h8C, 8'h6D, 8'h2D, 8'hCD, 8'hEC,
      8'hCC, 8'h4D, 8'h0D, 8'hED, 8'h4C:
        addr_mode = ABS;
      8'h0A, 8'h4A, 8'h2A, 8'h6A:
        addr_mode = ACC;
      8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0:
        addr_mode = REL;
      default:
        addr_mode = IMP;
    endcase
  end

endmodule

// ==== source/instr_classifier.sv ====
`timescale 1ns/1ns

module instr_classifier (
  input  ctrl_pkg::op_t        op,
  input  ctrl_pkg::addr_mode_t addr_mode,
  input  ctrl_pkg::flag_t      flag,
  decode_if.producer           dec
);
  import ctrl_pkg::*;

  data_t status;

  assign status = flag[DATA_W-1:0];

  assign dec.op          = op;
  assign dec.addr_mode   = addr_mode;
  assign dec.is_load     = op inside {OP_LDA, OP_LDX, OP_LDY};
  assign dec.is_store    = op inside {OP_STA, OP_STX, OP_STY};
  assign dec.is_transfer = op inside {OP_TAX, OP_TAY, OP_TSX, OP_TXA, OP_TXS, OP_TYA};
  assign dec.is_set      = op inside {OP_SEC, OP_SED, OP_SEI};
  assign dec.is_clear    = op inside {OP_CLC, OP_CLD, OP_CLI, OP_CLV};

  // Loads take the latched operand in T
  always_comb begin
    case (op)
      OP_TAX, OP_TAY: dec.mov_src = REG_A;
      OP_TXA, OP_TXS: dec.mov_src = REG_X;
      OP_TYA:         dec.mov_src = REG_Y;
      OP_TSX:         dec.mov_src = REG_S;
      default:        dec.mov_src = REG_T;
    endcase
  end

  always_comb begin
    case (op)
      OP_LDA, OP_TXA, OP_TYA: dec.mov_dst = REG_A;
      OP_LDX, OP_TAX, OP_TSX: dec.mov_dst = REG_X;
      OP_LDY, OP_TAY:         dec.mov_dst = REG_Y;
      OP_TXS:                 dec.mov_dst = REG_S;
      default:                dec.mov_dst = REG_T;
    endcase
  end

  // ALU operation
  always_comb begin
    case (op)
      OP_ADC:                 dec.exe_ctrl = ALU_ADC;
      OP_AND:                 dec.exe_ctrl = ALU_AND;
      OP_CMP, OP_CPX, OP_CPY: dec.exe_ctrl = ALU_CMP;
      OP_DEX, OP_DEY:         dec.exe_ctrl = ALU_DEC;
      OP_EOR:                 dec.exe_ctrl = ALU_EOR;
      OP_INX, OP_INY:         dec.exe_ctrl = ALU_INC;
      OP_ORA:                 dec.exe_ctrl = ALU_ORA;
      OP_SBC:                 dec.exe_ctrl = ALU_SBC;
      OP_ASL:                 dec.exe_ctrl = ALU_ASL;
      OP_LSR:                 dec.exe_ctrl = ALU_LSR;
      OP_ROL:                 dec.exe_ctrl = ALU_ROL;
      OP_ROR:                 dec.exe_ctrl = ALU_ROR;
      default:                dec.exe_ctrl = ALU_THA;
    endcase
  end

  // Operand A also names the register written back
  always_comb begin
    case (op)
      OP_ADC, OP_AND, OP_CMP, OP_EOR, OP_ORA, OP_SBC: dec.exe_src_a = ALU_SRC_A_A;
      OP_CPX, OP_INX, OP_DEX:                         dec.exe_src_a = ALU_SRC_A_X;
      OP_CPY, OP_INY, OP_DEY:                         dec.exe_src_a = ALU_SRC_A_Y;
      // Shifts only exist in accumulator form
      OP_ASL, OP_LSR, OP_ROL, OP_ROR:                 dec.exe_src_a = ALU_SRC_A_A;
      default:                                        dec.exe_src_a = ALU_SRC_A_T;
    endcase
  end

  always_comb begin
    case (op)
      OP_CLC, OP_SEC: dec.flag_mask = FLAG_MASK_C;
      OP_CLD, OP_SED: dec.flag_mask = FLAG_MASK_D;
      OP_CLI, OP_SEI: dec.flag_mask = FLAG_MASK_I;
      OP_CLV:         dec.flag_mask = FLAG_MASK_V;
      default:        dec.flag_mask = '0;
    endcase
  end

  // Branch condition on the tested status bit
  always_comb begin
    case (op)
      OP_BCC:  dec.branch_taken = ~|(status & FLAG_MASK_C);
      OP_BCS:  dec.branch_taken =  |(status & FLAG_MASK_C);
      OP_BNE:  dec.branch_taken = ~|(status & FLAG_MASK_Z);
      OP_BEQ:  dec.branch_taken =  |(status & FLAG_MASK_Z);
      OP_BVC:  dec.branch_taken = ~|(status & FLAG_MASK_V);
      OP_BVS:  dec.branch_taken =  |(status & FLAG_MASK_V);
      OP_BPL:  dec.branch_taken = ~|(status & FLAG_MASK_N);
      OP_BMI:  dec.branch_taken =  |(status & FLAG_MASK_N);
      default: dec.branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== source/cycle_sequencer.sv ====
`timescale 1ns/1ns

module cycle_sequencer (
  input  logic                   CLK,
  input  logic                   reset,
  input  logic                   rdy,
  input  ctrl_pkg::flag_t        flag,
  decode_if.sequencer            dec,
  output ctrl_pkg::cycle_state_t state
);
  import ctrl_pkg::*;

  cycle_state_t next_state;
  logic         page_carry;

  assign page_carry = |(flag & FLAG_MASK_PCC);

  // Cycle state, held while rdy is low
  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= T0_FETCH_OPCODE;
    end else if (rdy) begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = T0_FETCH_OPCODE;
    case (state)
      T0_FETCH_OPCODE: next_state = T1_FETCH_OPERAND;
      T1_FETCH_OPERAND: begin
        case (dec.addr_mode)
          ZPG:     next_state = dec.is_store ? TX_WRITE_DATA : TX_READ_DATA;
          ABS:     next_state = T2_ABS;
          REL:     next_state = dec.branch_taken ? T2_REL : TX_READ_DATA;
          default: next_state = T0_FETCH_OPCODE;
        endcase
      end
      T2_ABS: begin
        if (dec.op == OP_JMP)
          next_state = T0_FETCH_OPCODE;
        else if (dec.is_store)
          next_state = TX_WRITE_DATA;
        else
          next_state = TX_READ_DATA;
      end
      // Extra cycle only when the offset crossed a page
      T2_REL:  next_state = page_carry ? T3_REL : T0_FETCH_OPCODE;
      default: next_state = T0_FETCH_OPCODE;
    endcase
  end

  state_legal: assert property (@(posedge CLK) disable iff (reset)
    state inside {T0_FETCH_OPCODE, T1_FETCH_OPERAND, T2_ABS, T2_REL, T3_REL,
                  TX_READ_DATA, TX_WRITE_DATA})
    else $error("cycle state left the legal set");

  hold_on_stall: assert property (@(posedge CLK) disable iff (reset)
    !rdy |=> $stable(state))
    else $error("cycle state moved while rdy was low");

endmodule

// ==== source/control_decode.sv ====
`timescale 1ns/1ns

module control_decode (
  input  ctrl_pkg::cycle_state_t state,
  decode_if.control              dec,
  output logic                   r_w,
  output ctrl_pkg::db_src_t      db_out_src,
  output logic                   dl_we,
  output logic                   ir_we,
  output ctrl_pkg::pcadder_t     pcadder_ctrl,
  output ctrl_pkg::pcl_src_t     pcl_src,
  output ctrl_pkg::pch_src_t     pch_src,
  output logic                   pcl_we,
  output logic                   pch_we,
  output ctrl_pkg::reg_sel_t     reg_src,
  output logic                   a_we,
  output logic                   x_we,
  output logic                   y_we,
  output logic                   s_we,
  output logic                   t_we,
  output ctrl_pkg::psrc_t        p_src,
  output ctrl_pkg::data_t        p_mask,
  output ctrl_pkg::alu_ctrl_t    alu_ctrl,
  output ctrl_pkg::alu_src_a_t   alu_src_a,
  output ctrl_pkg::alu_src_b_t   alu_src_b,
  output ctrl_pkg::abl_src_t     abl_src,
  output ctrl_pkg::abh_src_t     abh_src,
  output logic                   abl_we,
  output logic                   abh_we
);
  import ctrl_pkg::*;

  always_comb begin
    r_w          = RW_READ;
    db_out_src   = DB_T;
    dl_we        = 1'b0;
    ir_we        = 1'b0;
    pcadder_ctrl = PCADDER_NOP;
    pcl_src      = PCL_SRC_MEM;
    pch_src      = PCH_SRC_MEM;
    pcl_we       = 1'b0;
    pch_we       = 1'b0;
    reg_src      = REG_MEM;
    a_we         = 1'b0;
    x_we         = 1'b0;
    y_we         = 1'b0;
    s_we         = 1'b0;
    t_we         = 1'b0;
    p_src        = P_SRC_NON;
    p_mask       = '0;
    alu_ctrl     = ALU_THA;
    alu_src_a    = ALU_SRC_A_A;
    alu_src_b    = ALU_SRC_B_MEM;
    abl_src      = ABL_SRC_PCN;
    abh_src      = ABH_SRC_PCN;
    abl_we       = 1'b0;
    abh_we       = 1'b0;

    case (state)
      T0_FETCH_OPCODE: begin
        ir_we        = 1'b1;
        pcadder_ctrl = PCADDER_INC;
        pcl_src      = PCL_SRC_ADD;
        pch_src      = PCH_SRC_ADD;
        pcl_we       = 1'b1;
        pch_we       = 1'b1;
        // Finish the previous instruction while the opcode is fetched
        if (dec.is_load || dec.is_transfer) begin
          reg_src = dec.mov_src;
          a_we    = dec.mov_dst == REG_A;
          x_we    = dec.mov_dst == REG_X;
          y_we    = dec.mov_dst == REG_Y;
          s_we    = dec.mov_dst == REG_S;
        end else begin
          reg_src   = REG_ALU;
          alu_ctrl  = dec.exe_ctrl;
          alu_src_a = dec.exe_src_a;
          alu_src_b = ALU_SRC_B_T;
          a_we      = dec.exe_src_a == ALU_SRC_A_A;
          x_we      = dec.exe_src_a == ALU_SRC_A_X;
          y_we      = dec.exe_src_a == ALU_SRC_A_Y;
        end
        p_mask = dec.flag_mask;
        if (dec.exe_ctrl != ALU_THA)
          p_src = P_SRC_ALU;
        else if (dec.is_set)
          p_src = P_SRC_SET;
        else if (dec.is_clear)
          p_src = P_SRC_CLR;
        abl_we = 1'b1;
        abh_we = 1'b1;
      end
      T1_FETCH_OPERAND: begin
        // One-byte instructions leave the PC alone
        if (dec.addr_mode inside {IMP, ACC})
          pcadder_ctrl = PCADDER_NOP;
        else
          pcadder_ctrl = PCADDER_INC;
        pcl_src = PCL_SRC_ADD;
        pch_src = PCH_SRC_ADD;
        pcl_we  = 1'b1;
        pch_we  = 1'b1;
        dl_we   = 1'b1;
        t_we    = 1'b1;
        abl_we  = 1'b1;
        abh_we  = 1'b1;
        if (dec.addr_mode == ZPG) begin
          abl_src = ABL_SRC_MEM;
          abh_src = ABH_SRC_H00;
        end
      end
      T2_ABS: begin
        dl_we        = 1'b1;
        pcadder_ctrl = PCADDER_INC;
        pcl_src      = (dec.op == OP_JMP) ? PCL_SRC_T : PCL_SRC_ADD;
        pch_src      = (dec.op == OP_JMP) ? PCH_SRC_MEM : PCH_SRC_ADD;
        pcl_we       = 1'b1;
        pch_we       = 1'b1;
        // Target address is high byte on the bus, low byte in T
        abl_src      = ABL_SRC_T;
        abh_src      = ABH_SRC_MEM;
        abl_we       = 1'b1;
        abh_we       = 1'b1;
      end
      T2_REL, T3_REL: begin
        // Offset added first, page carry applied in T3
        pcadder_ctrl = (state == T2_REL) ? PCADDER_ADD : PCADDER_CADD;
        pcl_src      = PCL_SRC_ADD;
        pch_src      = PCH_SRC_ADD;
        pcl_we       = 1'b1;
        pch_we       = 1'b1;
        abl_we       = 1'b1;
        abh_we       = 1'b1;
      end
      TX_READ_DATA: begin
        dl_we   = 1'b1;
        t_we    = 1'b1;
        abl_src = ABL_SRC_PCC;
        abh_src = ABH_SRC_PCC;
        abl_we  = 1'b1;
        abh_we  = 1'b1;
      end
      TX_WRITE_DATA: begin
        r_w = dec.is_store ? RW_WRITE : RW_READ;
        case (dec.op)
          OP_STA:  db_out_src = DB_A;
          OP_STX:  db_out_src = DB_X;
          OP_STY:  db_out_src = DB_Y;
          default: db_out_src = DB_T;
        endcase
        abl_src = ABL_SRC_PCC;
        abh_src = ABH_SRC_PCC;
        abl_we  = 1'b1;
        abh_we  = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    no_write_on_fetch: assert final (!(r_w == RW_WRITE && ir_we))
      else $error("write cycle during opcode fetch");
    one_reg_writer: assert final ($onehot0({a_we, x_we, y_we, s_we}))
      else $error("more than one register write enable");
  end

endmodule

// ==== source/cpu_controller.sv ====
`timescale 1ns/1ns

module cpu_controller (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 rdy,
  input  ctrl_pkg::data_t      instr,
  input  ctrl_pkg::flag_t      flag,
  output logic                 r_w,
  output ctrl_pkg::db_src_t    db_out_src,
  output logic                 dl_we,
  output logic                 ir_we,
  output ctrl_pkg::pcadder_t   pcadder_ctrl,
  output ctrl_pkg::pcl_src_t   pcl_src,
  output ctrl_pkg::pch_src_t   pch_src,
  output logic                 pcl_we,
  output logic                 pch_we,
  output ctrl_pkg::reg_sel_t   reg_src,
  output logic                 a_we,
  output logic                 x_we,
  output logic                 y_we,
  output logic                 s_we,
  output logic                 t_we,
  output ctrl_pkg::psrc_t      p_src,
  output ctrl_pkg::data_t      p_mask,
  output ctrl_pkg::alu_ctrl_t  alu_ctrl,
  output ctrl_pkg::alu_src_a_t alu_src_a,
  output ctrl_pkg::alu_src_b_t alu_src_b,
  output ctrl_pkg::abl_src_t   abl_src,
  output ctrl_pkg::abh_src_t   abh_src,
  output logic                 abl_we,
  output logic                 abh_we
);
  import ctrl_pkg::*;

  op_t          op;
  addr_mode_t   addr_mode;
  cycle_state_t state;

  decode_if dec ();

  opcode_decoder u_decoder (
    .instr     (instr),
    .op        (op),
    .addr_mode (addr_mode)
  );

  instr_classifier u_classifier (
    .op        (op),
    .addr_mode (addr_mode),
    .flag      (flag),
    .dec       (dec.producer)
  );

  cycle_sequencer u_sequencer (
    .CLK   (CLK),
    .reset (reset),
    .rdy   (rdy),
    .flag  (flag),
    .dec   (dec.sequencer),
    .state (state)
  );

  control_decode u_control (
    .state        (state),
    .dec          (dec.control),
    .r_w          (r_w),
    .db_out_src   (db_out_src),
    .dl_we        (dl_we),
    .ir_we        (ir_we),
    .pcadder_ctrl (pcadder_ctrl),
    .pcl_src      (pcl_src),
    .pch_src      (pch_src),
    .pcl_we       (pcl_we),
    .pch_we       (pch_we),
    .reg_src      (reg_src),
    .a_we         (a_we),
    .x_we         (x_we),
    .y_we         (y_we),
    .s_we         (s_we),
    .t_we         (t_we),
    .p_src        (p_src),
    .p_mask       (p_mask),
    .alu_ctrl     (alu_ctrl),
    .alu_src_a    (alu_src_a),
    .alu_src_b    (alu_src_b),
    .abl_src      (abl_src),
    .abh_src      (abh_src),
    .abl_we       (abl_we),
    .abh_we       (abh_we)
  );

endmodule

// ==== sim/tb_cpu_controller.sv ====
`timescale 1ns/1ns

module tb_cpu_controller;
  import ctrl_pkg::*;

  localparam int HALF_PERIOD  = 20;
  localparam int PERIOD       = 40;
  localparam int RESET_CYCLES = 16;
  localparam int SETTLE       = 10;
  localparam int STALL_LIMIT  = 40;
  localparam int MARGIN       = 24;

  logic       CLK;
  logic       reset;
  logic       rdy;
  data_t      instr;
  flag_t      flag;
  logic       r_w;
  db_src_t    db_out_src;
  logic       dl_we;
  logic       ir_we;
  pcadder_t   pcadder_ctrl;
  pcl_src_t   pcl_src;
  pch_src_t   pch_src;
  logic       pcl_we;
  logic       pch_we;
  reg_sel_t   reg_src;
  logic       a_we;
  logic       x_we;
  logic       y_we;
  logic       s_we;
  logic       t_we;
  psrc_t      p_src;
  data_t      p_mask;
  alu_ctrl_t  alu_ctrl;
  alu_src_a_t alu_src_a;
  alu_src_b_t alu_src_b;
  abl_src_t   abl_src;
  abh_src_t   abh_src;
  logic       abl_we;
  logic       abh_we;

  // All control outputs packed for the stall comparison
  logic [48:0] out_word;

  // One entry per stimulus line
  string stim_name[$];
  data_t stim_instr[$];
  flag_t stim_flag[$];
  int    exp_cycles[$];
  int    exp_writes[$];
  int    exp_db[$];
  int    exp_we[$];
  int    exp_reg[$];
  int    exp_alu[$];
  int    exp_psrc[$];
  int    exp_pmask[$];

  int   watch_limit;
  logic watch_armed;
  int   stalls_left;
  int   sum_cycles;

  cpu_controller uut (.*);

  assign out_word = {r_w, db_out_src, dl_we, ir_we, pcadder_ctrl, pcl_src, pch_src,
                     pcl_we, pch_we, reg_src, a_we, x_we, y_we, s_we, t_we, p_src,
                     p_mask, alu_ctrl, alu_src_a, alu_src_b, abl_src, abh_src,
                     abl_we, abh_we};

  always #HALF_PERIOD CLK = ~CLK;

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string test, input string field,
                             input longint expected, input longint actual);
    if (expected != actual) begin
      $display("MISMATCH %s %s expected %0h actual %0h", test, field, expected, actual);
      abort_run();
    end
  endtask

  // Operand A register behind the written register of an ALU op
  function automatic alu_src_a_t src_a_for_target(input int we_target);
    case (we_target)
      2:       return ALU_SRC_A_X;
      4:       return ALU_SRC_A_Y;
      default: return ALU_SRC_A_A;
    endcase
  endfunction

  task automatic load_stim();
    int    fd;
    int    got;
    string line;
    string name;
    data_t ins;
    flag_t flg;
    int    cyc;
    int    wr;
    int    db;
    int    we;
    int    rs;
    int    alu;
    int    ps;
    int    pm;
    fd = $fopen("sim/controller_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file sim/controller_stim.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      got = $fgets(line, fd);
      // Skip blank and comment lines
      if (got == 0 || line.len() < 2 || line[0] == "#")
        continue;
      got = $sscanf(line, "%s %h %h %d %d %h %h %h %h %h %h",
                    name, ins, flg, cyc, wr, db, we, rs, alu, ps, pm);
      if (got != 11) begin
        $display("stimulus line could not be parsed: %s", line);
        abort_run();
      end
      stim_name.push_back(name);
      stim_instr.push_back(ins);
      stim_flag.push_back(flg);
      exp_cycles.push_back(cyc);
      exp_writes.push_back(wr);
      exp_db.push_back(db);
      exp_we.push_back(we);
      exp_reg.push_back(rs);
      exp_alu.push_back(alu);
      exp_psrc.push_back(ps);
      exp_pmask.push_back(pm);
    end
    $fclose(fd);
    if (stim_name.size() == 0) begin
      $display("the stimulus file holds no tests");
      abort_run();
    end
  endtask

  // Random stalls stay within the watchdog budget
  task automatic choose_rdy();
    if (stalls_left > 0 && ($urandom % 4) == 0) begin
      rdy = 1'b0;
      stalls_left--;
    end else begin
      rdy = 1'b1;
    end
  endtask

  task automatic advance_cycle(input string name, input data_t next_instr,
                               input flag_t next_flag, output logic new_t0);
    logic        fetched;
    logic        was_t0;
    logic        was_rdy;
    logic [48:0] held;
    fetched = ir_we & rdy;
    was_t0  = ir_we;
    was_rdy = rdy;
    held    = out_word;
    @(negedge CLK);
    // IR loads only on an opcode fetch that was not stalled
    if (fetched) begin
      instr = next_instr;
      flag  = next_flag;
    end
    choose_rdy();
    #SETTLE;
    if (!was_rdy)
      check_value(name, "outputs over stall", longint'(held), longint'(out_word));
    new_t0 = ir_we & (was_rdy | ~was_t0);
  endtask

  task automatic run_instruction(input int idx);
    int    cycles;
    int    stalls;
    int    writes;
    int    db_seen;
    logic  new_t0;
    string name;
    name    = stim_name[idx];
    cycles  = 0;
    stalls  = 0;
    writes  = 0;
    db_seen = int'(DB_T);
    new_t0  = 1'b0;
    while (!new_t0) begin
      cycles++;
      if (!rdy)
        stalls++;
      if (r_w == RW_WRITE) begin
        db_seen = int'(db_out_src);
        if (rdy)
          writes++;
      end
      advance_cycle(name, stim_instr[idx], stim_flag[idx], new_t0);
    end
    // This opcode fetch completes the instruction
    check_value(name, "cycles", longint'(exp_cycles[idx] + stalls), longint'(cycles));
    check_value(name, "writes", longint'(exp_writes[idx]), longint'(writes));
    check_value(name, "db_out_src", longint'(exp_db[idx]), longint'(db_seen));
    check_value(name, "we target", longint'(exp_we[idx]),
                longint'({s_we, y_we, x_we, a_we}));
    check_value(name, "reg_src", longint'(exp_reg[idx]), longint'(reg_src));
    check_value(name, "alu_ctrl", longint'(exp_alu[idx]), longint'(alu_ctrl));
    check_value(name, "p_src", longint'(exp_psrc[idx]), longint'(p_src));
    check_value(name, "p_mask", longint'(exp_pmask[idx]), longint'(p_mask));
    // An ALU result goes back to the register that was operand A
    if (exp_reg[idx] == int'(REG_ALU) && exp_we[idx] != 0)
      check_value(name, "alu_src_a", longint'(src_a_for_target(exp_we[idx])),
                  longint'(alu_src_a));
  endtask

  initial begin
    CLK         = 1'b0;
    reset       = 1'b1;
    rdy         = 1'b1;
    instr       = 8'hEA;
    flag        = '0;
    watch_armed = 1'b0;
    watch_limit = 0;
    stalls_left = STALL_LIMIT;
    sum_cycles  = 0;
    void'($urandom(32'ha0e5));
    load_stim();
    foreach (exp_cycles[i])
      sum_cycles += exp_cycles[i];
    watch_limit = PERIOD * (RESET_CYCLES + sum_cycles + STALL_LIMIT + MARGIN);
    watch_armed = 1'b1;

    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    reset = 1'b0;
    choose_rdy();
    #SETTLE;
    // First cycle out of reset is an opcode fetch
    check_value("reset", "ir_we", longint'(1), longint'(ir_we));
    check_value("reset", "pcl_we", longint'(1), longint'(pcl_we));
    check_value("reset", "pch_we", longint'(1), longint'(pch_we));
    check_value("reset", "abl_we", longint'(1), longint'(abl_we));
    check_value("reset", "abh_we", longint'(1), longint'(abh_we));
    check_value("reset", "r_w", longint'(RW_READ), longint'(r_w));
    check_value("reset", "dl_we", longint'(0), longint'(dl_we));
    check_value("reset", "t_we", longint'(0), longint'(t_we));

    for (int i = 0; i < stim_name.size(); i++)
      run_instruction(i);
    $display("sim passed");
    $finish;
  end

  // Watchdog
  initial begin
    wait (watch_armed);
    #(watch_limit);
    $display("timeout, the run did not finish within %0d ns", watch_limit);
    abort_run();
  end

endmodule

// ==== build.f ====
source/ctrl_pkg.sv
source/decode_if.sv
source/opcode_decoder.sv
source/instr_classifier.sv
source/cycle_sequencer.sv
source/control_decode.sv
source/cpu_controller.sv
sim/tb_cpu_controller.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cpu_controller
FILELIST = build.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== sim/controller_stim.txt ====
# name instr flag cycles writes db_out_src we_target reg_src alu_ctrl p_src p_mask
# we_target bits 1 A, 2 X, 4 Y, 8 S; all columns hex except cycles and writes
lda_imm            a9 000 2 0 3 1 4 0 3 00
ldx_zpg            a6 000 3 0 3 2 4 0 3 00
ldy_abs            ac 000 4 0 3 4 4 0 3 00
sta_zpg            85 000 3 1 0 0 7 0 3 00
stx_abs            8e 000 4 1 1 0 7 0 3 00
sty_zpg            84 000 3 1 2 0 7 0 3 00
tax                aa 000 2 0 3 2 0 0 3 00
tsx                ba 000 2 0 3 2 3 0 3 00
txs                9a 000 2 0 3 8 1 0 3 00
tya                98 000 2 0 3 1 2 0 3 00
adc_imm            69 000 2 0 3 1 7 1 0 00
and_zpg            25 000 3 0 3 1 7 2 0 00
cmp_abs            cd 000 4 0 3 1 7 3 0 00
cpx_imm            e0 000 2 0 3 2 7 3 0 00
cpy_zpg            c4 000 3 0 3 4 7 3 0 00
eor_imm            49 000 2 0 3 1 7 5 0 00
sbc_abs            ed 000 4 0 3 1 7 8 0 00
inx                e8 000 2 0 3 2 7 6 0 00
dey                88 000 2 0 3 4 7 4 0 00
asl_acc            0a 000 2 0 3 1 7 9 0 00
ror_acc            6a 000 2 0 3 1 7 c 0 00
clv                b8 000 2 0 3 0 7 0 2 40
sec                38 000 2 0 3 0 7 0 1 01
cli                58 000 2 0 3 0 7 0 2 04
jmp_abs            4c 000 3 0 3 0 7 0 3 00
bcc_not_taken      90 001 3 0 3 0 7 0 3 00
beq_taken          f0 002 3 0 3 0 7 0 3 00
bmi_taken_pcc      30 180 4 0 3 0 7 0 3 00
bvc_taken_pcc      50 100 4 0 3 0 7 0 3 00
bne_not_taken_pcc  d0 102 3 0 3 0 7 0 3 00
unknown_ff         ff 000 2 0 3 0 7 0 3 00
